// File: gcd_matrix.f
+incdir+tests
src/gcd_cfg_pkg.sv
src/gcd_bus_pkg.sv
src/gcd_apb_regs.sv
src/gcd_dispatch.sv
src/gcd_lane.sv
src/gcd_collect.sv
src/gcd_matrix_top.sv
tests/gcd_matrix_tb.sv

// File: src/gcd_apb_regs.sv
//////////////////////////////////////////////////////////////////////
// APB slave for the matrix GCD subsystem. Holds control, status,
// size and modulus registers plus the A, B and R element memories.
// Zero wait states; errors reported on pslverr with the write dropped.
// The dispatcher reads operands through a combinational port and the
// collector writes results through res_wr.
//////////////////////////////////////////////////////////////////////

module gcd_apb_regs
  import gcd_cfg_pkg::*, gcd_bus_pkg::*;
(
  input  logic             CLK,
  input  logic             RST,
  input  apb_req_t         apb_req,
  output apb_rsp_t         apb_rsp,
  output logic             start_pulse,
  output logic [DIM_W-1:0] rows,
  output logic [DIM_W-1:0] cols,
  output elem_t            modulo,
  input  idx_t             rd_idx,
  output elem_t            a_elem,
  output elem_t            b_elem,
  input  mem_wr_t          res_wr,
  input  logic             all_done,
  output logic             irq
);

  logic access;
  logic is_ctrl, is_status, is_size, is_modulo;
  logic elem_ok, in_a, in_b, in_r, mapped;
  logic size_bad, err, wr_ok;
  logic [ADDR_W-REGION_LSB-1:0] region;
  logic [DIM_W-1:0] new_rows, new_cols;
  logic [PDATA_W-1:0] rdata;
  idx_t acc_idx;
  logic busy, done;

  elem_t mem_a [MAX_ELEM];
  elem_t mem_b [MAX_ELEM];
  elem_t mem_r [MAX_ELEM];

  ////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////

  assign access    = apb_req.psel & apb_req.penable;
  assign is_ctrl   = apb_req.paddr == REG_CTRL;
  assign is_status = apb_req.paddr == REG_STATUS;
  assign is_size   = apb_req.paddr == REG_SIZE;
  assign is_modulo = apb_req.paddr == REG_MODULO;

  // Window select and word offset inside it
  assign region  = apb_req.paddr[ADDR_W-1:REGION_LSB];
  assign acc_idx = apb_req.paddr[IDX_W+1:2];
  assign elem_ok = (apb_req.paddr[REGION_LSB-1:0] < (REGION_LSB)'(MAX_ELEM * 4)) &&
                   (apb_req.paddr[1:0] == 2'b00);
  assign in_a = elem_ok && (region == A_BASE[ADDR_W-1:REGION_LSB]);
  assign in_b = elem_ok && (region == B_BASE[ADDR_W-1:REGION_LSB]);
  assign in_r = elem_ok && (region == R_BASE[ADDR_W-1:REGION_LSB]);
  assign mapped = is_ctrl | is_status | is_size | is_modulo | in_a | in_b | in_r;

  // Size fields, each 1..MAX_DIM
  assign new_rows = apb_req.pwdata[SIZE_ROWS_LSB +: DIM_W];
  assign new_cols = apb_req.pwdata[SIZE_COLS_LSB +: DIM_W];
  assign size_bad = is_size && (new_rows == '0 || new_rows > DIM_W'(MAX_DIM) ||
                                new_cols == '0 || new_cols > DIM_W'(MAX_DIM));

  // Error cases; R is read only, STATUS writes are ignored
  assign err = !mapped ||
               (apb_req.pwrite && ((busy && !is_status) || size_bad || in_r));
  assign wr_ok = access && apb_req.pwrite && !err;

  // Start is only accepted when idle
  assign start_pulse = wr_ok && is_ctrl && apb_req.pwdata[CTRL_START_BIT];

  ////////////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata = '0;
    if (is_status) begin
      rdata[STAT_BUSY_BIT] = busy;
      rdata[STAT_DONE_BIT] = done;
    end else if (is_size) begin
      rdata[SIZE_ROWS_LSB +: DIM_W] = rows;
      rdata[SIZE_COLS_LSB +: DIM_W] = cols;
    end else if (is_modulo) begin
      rdata[DATA_W-1:0] = modulo;
    end else if (in_a) begin
      rdata[DATA_W-1:0] = mem_a[acc_idx];
    end else if (in_b) begin
      rdata[DATA_W-1:0] = mem_b[acc_idx];
    end else if (in_r) begin
      rdata[DATA_W-1:0] = mem_r[acc_idx];
    end
  end

  // No wait states
  assign apb_rsp.pready  = access;
  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pslverr = access && err;

  // Operand port for the dispatcher
  assign a_elem = mem_a[rd_idx];
  assign b_elem = mem_b[rd_idx];
  assign irq    = done;

  ////////////////////////////////////////////////////////////////////
  // Register and memory updates
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy   <= 1'b0;
      done   <= 1'b0;
      rows   <= '0;
      cols   <= '0;
      modulo <= '0;
      for (int i = 0; i < MAX_ELEM; i++) begin
        mem_a[i] <= '0;
        mem_b[i] <= '0;
        mem_r[i] <= '0;
      end
    end else begin
      // Run control
      if (start_pulse) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (all_done) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
      if (wr_ok && is_size) begin
        rows <= new_rows;
        cols <= new_cols;
      end
      if (wr_ok && is_modulo) begin
        modulo <= apb_req.pwdata[DATA_W-1:0];
      end
      if (wr_ok && in_a) begin
        mem_a[acc_idx] <= apb_req.pwdata[DATA_W-1:0];
      end
      if (wr_ok && in_b) begin
        mem_b[acc_idx] <= apb_req.pwdata[DATA_W-1:0];
      end
      // Results from the collector
      if (res_wr.en) begin
        mem_r[res_wr.idx] <= res_wr.data;
      end
    end
  end

  // Completion only ends a run that is in progress
  a_done_in_run: assert property (@(posedge CLK) disable iff (RST)
    all_done |-> busy);

endmodule

// File: src/gcd_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// APB transfer types and the register map of the GCD subsystem.
// The host side of the design and the testbench both import this
// package to decode and build accesses.
//////////////////////////////////////////////////////////////////////

package gcd_bus_pkg;

  localparam int ADDR_W  = 12;
  localparam int PDATA_W = 32;

  typedef struct packed {
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [ADDR_W-1:0]  paddr;
    logic [PDATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic               pready;
    logic [PDATA_W-1:0] prdata;
    logic               pslverr;
  } apb_rsp_t;

  ////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////

  localparam logic [ADDR_W-1:0] REG_CTRL   = 12'h000;
  localparam logic [ADDR_W-1:0] REG_STATUS = 12'h004;
  localparam logic [ADDR_W-1:0] REG_SIZE   = 12'h008;
  localparam logic [ADDR_W-1:0] REG_MODULO = 12'h00C;

  // Element windows, 4-byte stride by flat index
  localparam logic [ADDR_W-1:0] A_BASE = 12'h100;
  localparam logic [ADDR_W-1:0] B_BASE = 12'h200;
  localparam logic [ADDR_W-1:0] R_BASE = 12'h300;
  // Address bits above this select the window
  localparam int REGION_LSB = 8;

  // Field positions
  localparam int CTRL_START_BIT = 0;
  localparam int STAT_BUSY_BIT  = 0;
  localparam int STAT_DONE_BIT  = 1;
  localparam int SIZE_ROWS_LSB  = 0;
  localparam int SIZE_COLS_LSB  = 8;

endpackage

// File: src/gcd_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Sizing constants and payload types for the element datapath.
// Shared by the dispatcher, the GCD lanes, the collector and the
// register block; import with gcd_cfg_pkg::* in the module header.
//////////////////////////////////////////////////////////////////////

package gcd_cfg_pkg;

  // Matrix geometry
  localparam int DATA_W   = 16;
  localparam int MAX_DIM  = 4;
  localparam int MAX_ELEM = 16;
  localparam int IDX_W    = 4;
  localparam int DIM_W    = 3;

  // Lane array
  localparam int LANES  = 4;
  localparam int LANE_W = 2;
  // Result counter, holds up to MAX_ELEM
  localparam int CNT_W  = 5;

  typedef logic [DATA_W-1:0] elem_t;
  // Flat index, row * MAX_DIM + col
  typedef logic [IDX_W-1:0]  idx_t;

  typedef struct packed {
    idx_t  idx;
    elem_t a;
    elem_t b;
    elem_t modulo;
  } gcd_job_t;

  typedef struct packed {
    idx_t  idx;
    elem_t value;
  } gcd_res_t;

  // Result memory write port
  typedef struct packed {
    logic  en;
    idx_t  idx;
    elem_t data;
  } mem_wr_t;

endpackage

// File: src/gcd_collect.sv
//////////////////////////////////////////////////////////////////////
// Round-robin drain of the lane results. Each granted result becomes
// a result memory write one cycle later; all_done pulses once the
// written count reaches rows x cols.
//////////////////////////////////////////////////////////////////////

module gcd_collect
  import gcd_cfg_pkg::*;
(
  input  logic             CLK,
  input  logic             RST,
  input  logic             start_pulse,
  input  logic [DIM_W-1:0] rows,
  input  logic [DIM_W-1:0] cols,
  input  logic             res_valid [LANES],
  input  gcd_res_t         res       [LANES],
  output logic             res_ready [LANES],
  output mem_wr_t          res_wr,
  output logic             all_done
);

  logic [LANE_W-1:0] ptr, gnt;
  logic any_valid, active;
  logic [CNT_W-1:0] cnt, total;

  assign total = CNT_W'(rows) * CNT_W'(cols);

  // First valid lane at or after ptr
  always_comb begin
    logic [LANE_W-1:0] cand;
    any_valid = 1'b0;
    gnt       = ptr;
    for (int k = LANES - 1; k >= 0; k--) begin
      cand = ptr + LANE_W'(k);
      if (res_valid[cand]) begin
        any_valid = 1'b1;
        gnt       = cand;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      res_ready[i] = any_valid && (gnt == LANE_W'(i));
    end
  end

  // One cycle after the last write
  assign all_done = active && (cnt == total);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ptr    <= '0;
      res_wr <= '0;
      cnt    <= '0;
      active <= 1'b0;
    end else begin
      res_wr.en <= any_valid;
      if (any_valid) begin
        res_wr.idx  <= res[gnt].idx;
        res_wr.data <= res[gnt].value;
        ptr         <= gnt + 1'b1;
      end
      // Completion count
      if (start_pulse) begin
        cnt    <= '0;
        active <= 1'b1;
      end else begin
        if (all_done) begin
          active <= 1'b0;
        end
        if (res_wr.en) begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  a_wr_in_region: assert property (@(posedge CLK) disable iff (RST)
    res_wr.en |-> (res_wr.idx / MAX_DIM) < rows && (res_wr.idx % MAX_DIM) < cols);

endmodule

// File: src/gcd_dispatch.sv
//////////////////////////////////////////////////////////////////////
// Element scheduler. Walks the active rows x cols region in row-major
// order, fetches A and B through the register block read port and
// offers each job to the lowest-numbered free lane.
//////////////////////////////////////////////////////////////////////

module gcd_dispatch
  import gcd_cfg_pkg::*;
(
  input  logic             CLK,
  input  logic             RST,
  input  logic             start_pulse,
  input  logic [DIM_W-1:0] rows,
  input  logic [DIM_W-1:0] cols,
  input  elem_t            modulo,
  output idx_t             rd_idx,
  input  elem_t            a_elem,
  input  elem_t            b_elem,
  output logic             job_valid [LANES],
  output gcd_job_t         job       [LANES],
  input  logic             job_ready [LANES]
);

  logic walking, pend_valid;
  logic any_ready, accepted, load, last_elem;
  logic [DIM_W-1:0]  row_q, col_q;
  logic [LANE_W-1:0] sel;
  gcd_job_t pend_job;

  // Flat index with MAX_DIM stride
  assign rd_idx = idx_t'(row_q * MAX_DIM + col_q);
  assign last_elem = (row_q == rows - 1'b1) && (col_q == cols - 1'b1);

  // Lowest ready lane wins
  always_comb begin
    any_ready = 1'b0;
    sel       = '0;
    for (int i = LANES - 1; i >= 0; i--) begin
      if (job_ready[i]) begin
        any_ready = 1'b1;
        sel       = LANE_W'(i);
      end
    end
  end

  // Valid only goes to a lane already ready, so the offer completes at once
  assign accepted = pend_valid && any_ready;
  assign load     = walking && (!pend_valid || accepted);

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      job_valid[i] = accepted && (sel == LANE_W'(i));
      job[i]       = pend_job;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      walking    <= 1'b0;
      pend_valid <= 1'b0;
      row_q      <= '0;
      col_q      <= '0;
      pend_job   <= '0;
    end else begin
      if (start_pulse && !walking && !pend_valid) begin
        row_q   <= '0;
        col_q   <= '0;
        // Empty region never starts
        walking <= (rows != '0) && (cols != '0);
      end else if (load) begin
        pend_job <= '{idx: rd_idx, a: a_elem, b: b_elem, modulo: modulo};
        if (col_q == cols - 1'b1) begin
          col_q <= '0;
          row_q <= row_q + 1'b1;
        end else begin
          col_q <= col_q + 1'b1;
        end
        if (last_elem) begin
          walking <= 1'b0;
        end
      end
      // Pending slot
      if (load) begin
        pend_valid <= 1'b1;
      end else if (accepted) begin
        pend_valid <= 1'b0;
      end
    end
  end

  a_job_stable: assert property (@(posedge CLK) disable iff (RST)
    pend_valid && !accepted |=> pend_valid && $stable(pend_job));

endmodule

// File: src/gcd_lane.sv
//////////////////////////////////////////////////////////////////////
// One GCD engine. Subtractive Euclid, one step per cycle, followed by
// reduction modulo the job's modulus by repeated subtraction.
// Valid/ready on both sides; one job in flight per lane.
//////////////////////////////////////////////////////////////////////

module gcd_lane
  import gcd_cfg_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  logic     in_valid,
  input  gcd_job_t in_job,
  output logic     in_ready,
  output logic     out_valid,
  output gcd_res_t out_res,
  input  logic     out_ready
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_EUCLID,
    S_REDUCE,
    S_HOLD
  } state_t;

  state_t state;
  elem_t  x_q, y_q, mod_q;
  idx_t   idx_q;

  assign in_ready  = state == S_IDLE;
  assign out_valid = state == S_HOLD;
  // Result lives in x once Euclid ends
  assign out_res   = '{idx: idx_q, value: x_q};

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= S_IDLE;
      x_q   <= '0;
      y_q   <= '0;
      mod_q <= '0;
      idx_q <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (in_valid) begin
            x_q   <= in_job.a;
            y_q   <= in_job.b;
            mod_q <= in_job.modulo;
            idx_q <= in_job.idx;
            state <= S_EUCLID;
          end
        end
        S_EUCLID: begin
          if (x_q == '0 || y_q == '0) begin
            // gcd(x,0) = x, gcd(0,0) = 0
            x_q   <= x_q | y_q;
            y_q   <= '0;
            state <= (mod_q == '0) ? S_HOLD : S_REDUCE;
          end else if (x_q >= y_q) begin
            x_q <= x_q - y_q;
          end else begin
            y_q <= y_q - x_q;
          end
        end
        S_REDUCE: begin
          if (x_q >= mod_q) begin
            x_q <= x_q - mod_q;
          end else begin
            state <= S_HOLD;
          end
        end
        S_HOLD: begin
          // Wait for the collector
          if (out_ready) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // A job offered to a busy lane would be lost
  a_offer_when_ready: assert property (@(posedge CLK) disable iff (RST)
    in_valid |-> in_ready);

endmodule

// File: src/gcd_matrix_top.sv
//////////////////////////////////////////////////////////////////////
// Matrix GCD subsystem top. APB registers feed the dispatcher, which
// spreads element jobs over the lane array; the collector writes the
// results back. irq follows the sticky done bit.
//////////////////////////////////////////////////////////////////////

module gcd_matrix_top
  import gcd_cfg_pkg::*, gcd_bus_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  output logic     irq
);

  // Register block to datapath
  logic             start_pulse;
  logic [DIM_W-1:0] rows, cols;
  elem_t            modulo;
  idx_t             rd_idx;
  elem_t            a_elem, b_elem;
  mem_wr_t          res_wr;
  logic             all_done;

  // Lane handshakes
  logic     job_valid [LANES];
  gcd_job_t job       [LANES];
  logic     job_ready [LANES];
  logic     res_valid [LANES];
  gcd_res_t res       [LANES];
  logic     res_ready [LANES];

  gcd_apb_regs i_regs (
    .CLK         (CLK),
    .RST         (RST),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .start_pulse (start_pulse),
    .rows        (rows),
    .cols        (cols),
    .modulo      (modulo),
    .rd_idx      (rd_idx),
    .a_elem      (a_elem),
    .b_elem      (b_elem),
    .res_wr      (res_wr),
    .all_done    (all_done),
    .irq         (irq)
  );

  gcd_dispatch i_dispatch (
    .CLK         (CLK),
    .RST         (RST),
    .start_pulse (start_pulse),
    .rows        (rows),
    .cols        (cols),
    .modulo      (modulo),
    .rd_idx      (rd_idx),
    .a_elem      (a_elem),
    .b_elem      (b_elem),
    .job_valid   (job_valid),
    .job         (job),
    .job_ready   (job_ready)
  );

  // Lane array
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    gcd_lane i_lane (
      .CLK       (CLK),
      .RST       (RST),
      .in_valid  (job_valid[i]),
      .in_job    (job[i]),
      .in_ready  (job_ready[i]),
      .out_valid (res_valid[i]),
      .out_res   (res[i]),
      .out_ready (res_ready[i])
    );
  end

  gcd_collect i_collect (
    .CLK         (CLK),
    .RST         (RST),
    .start_pulse (start_pulse),
    .rows        (rows),
    .cols        (cols),
    .res_valid   (res_valid),
    .res         (res),
    .res_ready   (res_ready),
    .res_wr      (res_wr),
    .all_done    (all_done)
  );

endmodule

// File: tests/gcd_matrix_tasks.svh
//////////////////////////////////////////////////////////////////////
// Testbench helpers for the matrix GCD subsystem: APB master tasks,
// typed compare tasks, xorshift source and the gcd-mod reference.
// Included inside the testbench module body.
//////////////////////////////////////////////////////////////////////

`ifndef GCD_MATRIX_TASKS_SVH
`define GCD_MATRIX_TASKS_SVH

// Setup cycle, then access cycle; response sampled mid-cycle
task automatic apb_transfer(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [PDATA_W-1:0] wdata,
                            output logic [PDATA_W-1:0] rdata, output logic slverr);
  int waits;
  waits = 0;
  @(posedge CLK);
  apb_req.psel    <= 1'b1;
  apb_req.penable <= 1'b0;
  apb_req.pwrite  <= wr;
  apb_req.paddr   <= addr;
  apb_req.pwdata  <= wdata;
  @(posedge CLK);
  apb_req.penable <= 1'b1;
  @(negedge CLK);
  while (!apb_rsp.pready && waits < APB_WAIT_MAX) begin
    @(negedge CLK);
    waits++;
  end
  if (!apb_rsp.pready) begin
    $display("APB slave never raised pready at address %h", addr);
    fail_cnt++;
  end
  rdata  = apb_rsp.prdata;
  slverr = apb_rsp.pslverr;
  // Transfer completes on this edge
  @(posedge CLK);
  apb_req.psel    <= 1'b0;
  apb_req.penable <= 1'b0;
endtask

task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [PDATA_W-1:0] data,
                         output logic slverr);
  logic [PDATA_W-1:0] unused;
  apb_transfer(1'b1, addr, data, unused, slverr);
endtask

task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [PDATA_W-1:0] data,
                        output logic slverr);
  apb_transfer(1'b0, addr, '0, data, slverr);
endtask

// 32-bit xorshift, state in rng_state
function automatic logic [31:0] next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// Division-based Euclid, then optional reduction
function automatic elem_t gcd_mod_ref(input elem_t a, input elem_t b, input elem_t m);
  elem_t x, y, t;
  x = a;
  y = b;
  while (y != 0) begin
    t = x % y;
    x = y;
    y = t;
  end
  if (m != 0) begin
    x = x % m;
  end
  return x;
endfunction

task automatic check_elem(input string test, input elem_t exp, input elem_t act);
  if (act !== exp) begin
    $display("ERR %s: expected %0d, actual %0d", test, exp, act);
    err_cnt++;
  end
endtask

task automatic check_rsp_err(input string test, input logic exp, input logic act);
  if (act !== exp) begin
    $display("ERR %s: expected pslverr %b, actual %b", test, exp, act);
    err_cnt++;
  end
endtask

task automatic check_status(input string test, input logic exp_busy, input logic exp_done,
                            input logic [PDATA_W-1:0] act);
  logic [PDATA_W-1:0] exp;
  exp = '0;
  exp[STAT_BUSY_BIT] = exp_busy;
  exp[STAT_DONE_BIT] = exp_done;
  if (act !== exp) begin
    $display("ERR %s: expected status %h, actual %h", test, exp, act);
    err_cnt++;
  end
endtask

task automatic check_irq(input string test, input logic exp, input logic act);
  if (act !== exp) begin
    $display("ERR %s: expected irq %b, actual %b", test, exp, act);
    err_cnt++;
  end
endtask

// Poll STATUS until done, bounded by DONE_POLL_MAX reads
task automatic wait_done(input string test);
  logic [PDATA_W-1:0] st;
  logic slverr;
  int polls;
  polls = 0;
  st    = '0;
  while (!st[STAT_DONE_BIT] && polls < DONE_POLL_MAX) begin
    apb_read(REG_STATUS, st, slverr);
    polls++;
  end
  if (!st[STAT_DONE_BIT]) begin
    $display("%s: run never finished, done bit still low after %0d polls", test, polls);
    fail_cnt++;
  end else begin
    check_status(test, 1'b0, 1'b1, st);
    @(negedge CLK);
    check_irq(test, 1'b1, irq);
  end
endtask

`endif

// File: tests/gcd_matrix_tb.sv
//////////////////////////////////////////////////////////////////////
// Directed testbench for the matrix GCD subsystem. Drives the APB
// port of gcd_matrix_top and checks register readback, single and
// full matrix runs, error responses and restart behavior.
//////////////////////////////////////////////////////////////////////

module gcd_matrix_tb
  import gcd_cfg_pkg::*, gcd_bus_pkg::*;
();

  localparam int APB_WAIT_MAX  = 16;
  localparam int DONE_POLL_MAX = 100000;

  logic     CLK;
  logic     RST;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic     irq;

  // Value mismatches, then timeouts and protocol failures
  int err_cnt;
  int fail_cnt;
  logic [31:0] rng_state;
  // Expected content of the result memory
  elem_t exp_r [MAX_ELEM];

  gcd_matrix_top i_dut (
    .CLK     (CLK),
    .RST     (RST),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .irq     (irq)
  );

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;

  `include "gcd_matrix_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // Run helpers
  //////////////////////////////////////////////////////////////////////

  // Start, then busy set and done cleared right away
  task automatic start_run(input string test);
    logic [PDATA_W-1:0] st;
    logic slverr;
    apb_write(REG_CTRL, 32'h1, slverr);
    check_rsp_err(test, 1'b0, slverr);
    apb_read(REG_STATUS, st, slverr);
    check_status(test, 1'b1, 1'b0, st);
    @(negedge CLK);
    check_irq(test, 1'b0, irq);
  endtask

  // Random operands with a shared factor so the gcd is nontrivial
  task automatic load_random(input string test, input int nrows, input int ncols);
    elem_t factor, a, b, m;
    logic [PDATA_W-1:0] size_word;
    logic slverr;
    int idx, r, c;
    m = elem_t'(next_rand() % 15) + 16'd2;
    size_word = '0;
    size_word[SIZE_ROWS_LSB +: DIM_W] = DIM_W'(nrows);
    size_word[SIZE_COLS_LSB +: DIM_W] = DIM_W'(ncols);
    apb_write(REG_SIZE, size_word, slverr);
    check_rsp_err(test, 1'b0, slverr);
    apb_write(REG_MODULO, PDATA_W'(m), slverr);
    check_rsp_err(test, 1'b0, slverr);
    for (r = 0; r < nrows; r++) begin
      for (c = 0; c < ncols; c++) begin
        idx    = r * MAX_DIM + c;
        factor = elem_t'(next_rand() % 64) + 16'd1;
        a      = factor * elem_t'(next_rand() % 1024);
        b      = factor * elem_t'(next_rand() % 1024);
        apb_write(A_BASE + ADDR_W'(idx * 4), PDATA_W'(a), slverr);
        check_rsp_err(test, 1'b0, slverr);
        apb_write(B_BASE + ADDR_W'(idx * 4), PDATA_W'(b), slverr);
        check_rsp_err(test, 1'b0, slverr);
        exp_r[idx] = gcd_mod_ref(a, b, m);
      end
    end
  endtask

  // Whole result memory, inactive slots keep older results
  task automatic check_results(input string test);
    logic [PDATA_W-1:0] rd;
    logic slverr;
    for (int i = 0; i < MAX_ELEM; i++) begin
      apb_read(R_BASE + ADDR_W'(i * 4), rd, slverr);
      check_elem($sformatf("%s R[%0d]", test, i), exp_r[i], rd[DATA_W-1:0]);
    end
  endtask

  task automatic run_single(input string test, input elem_t a, input elem_t b,
                            input elem_t m, input elem_t exp);
    logic [PDATA_W-1:0] rd;
    logic slverr;
    apb_write(REG_SIZE, 32'h0000_0101, slverr);
    apb_write(REG_MODULO, PDATA_W'(m), slverr);
    apb_write(A_BASE, PDATA_W'(a), slverr);
    apb_write(B_BASE, PDATA_W'(b), slverr);
    start_run(test);
    wait_done(test);
    apb_read(R_BASE, rd, slverr);
    check_elem(test, exp, rd[DATA_W-1:0]);
    exp_r[0] = exp;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_readback();
    logic [PDATA_W-1:0] rd;
    logic slverr;
    apb_read(REG_STATUS, rd, slverr);
    check_status("reset status", 1'b0, 1'b0, rd);
    @(negedge CLK);
    check_irq("reset irq", 1'b0, irq);
    apb_write(REG_SIZE, 32'h0000_0203, slverr);
    check_rsp_err("size write", 1'b0, slverr);
    apb_read(REG_SIZE, rd, slverr);
    check_elem("size readback", 16'h0203, rd[DATA_W-1:0]);
    apb_write(REG_MODULO, 32'h0000_1234, slverr);
    apb_read(REG_MODULO, rd, slverr);
    check_elem("modulo readback", 16'h1234, rd[DATA_W-1:0]);
    apb_write(A_BASE + 12'h014, 32'h0000_beef, slverr);
    apb_read(A_BASE + 12'h014, rd, slverr);
    check_elem("A[5] readback", 16'hbeef, rd[DATA_W-1:0]);
    apb_write(B_BASE + 12'h024, 32'h0000_1357, slverr);
    apb_read(B_BASE + 12'h024, rd, slverr);
    check_elem("B[9] readback", 16'h1357, rd[DATA_W-1:0]);
  endtask

  task automatic error_responses();
    logic [PDATA_W-1:0] rd;
    logic slverr;
    apb_write(REG_SIZE, 32'h0000_0402, slverr);
    check_rsp_err("good size", 1'b0, slverr);
    apb_write(REG_SIZE, 32'h0000_0400, slverr);
    check_rsp_err("size rows 0", 1'b1, slverr);
    apb_read(REG_SIZE, rd, slverr);
    check_elem("size kept after rows 0", 16'h0402, rd[DATA_W-1:0]);
    apb_write(REG_SIZE, 32'h0000_0405, slverr);
    check_rsp_err("size rows 5", 1'b1, slverr);
    apb_read(REG_SIZE, rd, slverr);
    check_elem("size kept after rows 5", 16'h0402, rd[DATA_W-1:0]);
    apb_write(12'h010, 32'h1, slverr);
    check_rsp_err("unmapped write", 1'b1, slverr);
    // Long Euclid chain keeps the DUT busy
    apb_write(REG_SIZE, 32'h0000_0101, slverr);
    apb_write(REG_MODULO, 32'h0, slverr);
    apb_write(A_BASE, 32'd5000, slverr);
    apb_write(B_BASE, 32'd1, slverr);
    start_run("busy run");
    apb_write(A_BASE, 32'h0000_1111, slverr);
    check_rsp_err("A write while busy", 1'b1, slverr);
    apb_read(A_BASE, rd, slverr);
    check_rsp_err("A read while busy", 1'b0, slverr);
    check_elem("A kept while busy", 16'd5000, rd[DATA_W-1:0]);
    apb_write(REG_CTRL, 32'h1, slverr);
    check_rsp_err("start while busy", 1'b1, slverr);
    wait_done("busy run");
    exp_r[0] = 16'd1;
    check_results("busy run");
  endtask

  initial begin
    RST       = 1'b1;
    apb_req   <= '0;
    err_cnt   = 0;
    fail_cnt  = 0;
    rng_state = 32'd92;
    for (int i = 0; i < MAX_ELEM; i++) begin
      exp_r[i] = '0;
    end
    repeat (8) @(posedge CLK);
    RST <= 1'b0;

    reset_readback();
    run_single("gcd 12 18", 16'd12, 16'd18, 16'd0, 16'd6);
    run_single("gcd 12 18 mod 4", 16'd12, 16'd18, 16'd4, 16'd2);
    run_single("gcd 0 7", 16'd0, 16'd7, 16'd0, 16'd7);
    run_single("gcd 0 0", 16'd0, 16'd0, 16'd0, 16'd0);
    load_random("full 4x4", 4, 4);
    start_run("full 4x4");
    wait_done("full 4x4");
    check_results("full 4x4");
    load_random("2x3", 2, 3);
    start_run("2x3");
    wait_done("2x3");
    check_results("2x3");
    error_responses();
    // Restart from the done state
    load_random("restart", 2, 2);
    start_run("restart");
    wait_done("restart");
    check_results("restart");

    $display("errors: %0d value mismatches, %0d other failures", err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
